/* source/spritePkg.sv */
/*
 * Sprite stage package
 * Width types and fixed sizes shared by the sprite output stage
 */
`default_nettype none

package spritePkg;

	// One bitplane byte of a sprite row
	typedef logic [7:0] planeByte_t;

	// Pixel index, one bit from each plane
	typedef logic [3:0] pixel_t;

	// Colour attribute of a sprite
	typedef logic [7:0] colour_t;

	// Line buffer word, colour above pixel
	typedef logic [11:0] pixelCode_t;

	// Buffer address or horizontal position
	typedef logic [8:0] xPos_t;

	// Vertical line counter
	typedef logic [8:0] lineCount_t;

	localparam int ROW_PIXELS = 8;	// Pixels per sprite row
	localparam int LB_DEPTH = 512;	// Entries per bank

endpackage

`default_nettype wire

/* source/videoTiming.sv */
/*
 * Video timing generator
 * Horizontal and vertical counters with sync, blank and new-line decode
 */
`timescale 1ns/1ps
`default_nettype none

module videoTiming
	import spritePkg::*;
#(
	parameter int H_TOTAL = 384,
	parameter int H_VISIBLE = 256,
	parameter int H_SYNC_START = 296,
	parameter int H_SYNC_LEN = 32,
	parameter int V_TOTAL = 264,
	parameter int V_VISIBLE = 224,
	parameter int V_SYNC_START = 240,
	parameter int V_SYNC_LEN = 8
) (
	input wire logic clk_12M,
	input wire logic RES,
	output xPos_t hCount,
	output logic visible,
	output logic newLine,
	output logic nHBlank,
	output logic nVBlank,
	output logic nHSync,
	output logic nVSync
);

	lineCount_t vCount;
	logic lineEnd;
	logic hSyncOn;
	logic vSyncOn;

	assign lineEnd = (hCount == xPos_t'(H_TOTAL - 1));

	always_ff @(posedge clk_12M or negedge RES) begin
		if (!RES) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			if (vCount == lineCount_t'(V_TOTAL - 1))	// Frame wrap
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	// Sync windows
	assign hSyncOn = (hCount >= xPos_t'(H_SYNC_START)) &&
		(hCount < xPos_t'(H_SYNC_START + H_SYNC_LEN));
	assign vSyncOn = (vCount >= lineCount_t'(V_SYNC_START)) &&
		(vCount < lineCount_t'(V_SYNC_START + V_SYNC_LEN));

	assign nHSync = ~hSyncOn;
	assign nVSync = ~vSyncOn;

	assign nHBlank = (hCount < xPos_t'(H_VISIBLE));
	assign nVBlank = (vCount < lineCount_t'(V_VISIBLE));
	assign visible = nHBlank & nVBlank;

	assign newLine = lineEnd;	// Last clock of the line

endmodule

`default_nettype wire

/* source/spriteSerializer.sv */
/*
 * Sprite row serializer
 * Shifts four plane bytes out as eight pixel writes into the line buffer
 */
`timescale 1ns/1ps
`default_nettype none

module spriteSerializer
	import spritePkg::*;
(
	input wire logic clk_12M,
	input wire logic RES,
	input wire logic load,
	input planeByte_t plane0,
	input planeByte_t plane1,
	input planeByte_t plane2,
	input planeByte_t plane3,
	input colour_t colour,
	input xPos_t xPos,
	input wire logic newLine,
	output logic busy,
	output logic wrEn,
	output xPos_t wrAddr,
	output pixelCode_t wrData
);

	typedef enum logic {
		stIdle,
		stShift
	} serState_t;

	serState_t state;
	logic [$clog2(ROW_PIXELS)-1:0] pixCount;
	planeByte_t shift0, shift1, shift2, shift3;
	colour_t colourReg;
	xPos_t xBase;
	pixel_t curPixel;
	logic acceptLoad;

	assign busy = (state == stShift);
	assign acceptLoad = load & ~busy;

	always_ff @(posedge clk_12M or negedge RES) begin
		if (!RES) begin
			state <= stIdle;
			pixCount <= '0;
		end else if (busy && newLine) begin
			state <= stIdle;	// Row cut off at end of line
		end else if (acceptLoad) begin
			state <= stShift;
			pixCount <= '0;
		end else if (busy) begin
			pixCount <= pixCount + 1'b1;
			if (pixCount == ($clog2(ROW_PIXELS))'(ROW_PIXELS - 1))
				state <= stIdle;
		end
	end

	always_ff @(posedge clk_12M) begin
		if (acceptLoad) begin
			shift0 <= plane0;
			shift1 <= plane1;
			shift2 <= plane2;
			shift3 <= plane3;
			colourReg <= colour;
			xBase <= xPos;
		end else if (busy) begin
			shift0 <= {shift0[6:0], 1'b0};	// MSB first
			shift1 <= {shift1[6:0], 1'b0};
			shift2 <= {shift2[6:0], 1'b0};
			shift3 <= {shift3[6:0], 1'b0};
		end
	end

	assign curPixel = {shift3[7], shift2[7], shift1[7], shift0[7]};

	assign wrAddr = xBase + xPos_t'(pixCount);	// Wraps at 512
	assign wrData = {colourReg, curPixel};
	assign wrEn = busy && (curPixel != '0);	// Pixel 0 is transparent

endmodule

`default_nettype wire

/* source/lineBuffer.sv */
/*
 * Double-buffered sprite line buffer
 * One bank is drawn while the other is scanned out and erased
 */
`timescale 1ns/1ps
`default_nettype none

module lineBuffer
	import spritePkg::*;
#(
	parameter int H_VISIBLE = 256
) (
	input wire logic clk_12M,
	input wire logic RES,
	input wire logic newLine,
	input xPos_t hCount,
	input wire logic visible,
	input wire logic wrEn,
	input xPos_t wrAddr,
	input pixelCode_t wrData,
	output pixelCode_t rdData
);

	pixelCode_t mem [2][LB_DEPTH];
	logic [LB_DEPTH-1:0] valid [2];
	logic drawSel;	// Bank being drawn
	logic wrHit;
	logic rdValid;
	pixelCode_t rdWord;

	assign wrHit = wrEn && (wrAddr < xPos_t'(H_VISIBLE));

	always_ff @(posedge clk_12M or negedge RES) begin
		if (!RES) begin
			drawSel <= 1'b0;
			valid[0] <= '0;
			valid[1] <= '0;
			rdValid <= 1'b0;
		end else begin
			if (newLine)
				drawSel <= ~drawSel;
			if (wrHit)
				valid[drawSel][wrAddr] <= 1'b1;
			if (visible)
				valid[~drawSel][hCount] <= 1'b0;	// Erase after read
			rdValid <= visible && valid[~drawSel][hCount];
		end
	end

	always_ff @(posedge clk_12M) begin
		if (wrHit)
			mem[drawSel][wrAddr] <= wrData;
		rdWord <= mem[~drawSel][hCount];
	end

	// Empty entries read as zero
	assign rdData = rdValid ? rdWord : '0;

endmodule

`default_nettype wire

/* source/pixelOutput.sv */
/*
 * Pixel output stage
 * Aligns syncs and blanks with the pixel word and drives the opaque flag
 */
`timescale 1ns/1ps
`default_nettype none

module pixelOutput
	import spritePkg::*;
(
	input wire logic clk_12M,
	input wire logic RES,
	input pixelCode_t rdData,
	input wire logic visible,
	input wire logic nHBlank,
	input wire logic nVBlank,
	input wire logic nHSync,
	input wire logic nVSync,
	output pixelCode_t ob,
	output logic nOpaque,
	output logic nHBlankOut,
	output logic nVBlankOut,
	output logic nHSyncOut,
	output logic nVSyncOut,
	output logic nCSync
);

	logic [1:0] visD;
	logic [1:0] hBlankD, vBlankD, hSyncD, vSyncD;
	pixelCode_t obReg;
	pixel_t obPixel;

	always_ff @(posedge clk_12M or negedge RES) begin
		if (!RES) begin
			visD <= '0;
			hBlankD <= '1;
			vBlankD <= '1;
			hSyncD <= '1;
			vSyncD <= '1;
		end else begin
			visD <= {visD[0], visible};
			hBlankD <= {hBlankD[0], nHBlank};
			vBlankD <= {vBlankD[0], nVBlank};
			hSyncD <= {hSyncD[0], nHSync};
			vSyncD <= {vSyncD[0], nVSync};
		end
	end

	always_ff @(posedge clk_12M) begin
		obReg <= rdData;	// Second pipeline stage
	end

	assign ob = visD[1] ? obReg : '0;
	assign obPixel = ob[3:0];
	assign nOpaque = (obPixel == '0);

	assign nHBlankOut = hBlankD[1];
	assign nVBlankOut = vBlankD[1];
	assign nHSyncOut = hSyncD[1];
	assign nVSyncOut = vSyncD[1];
	assign nCSync = hSyncD[1] & vSyncD[1];

endmodule

`default_nettype wire

/* source/spriteVideo.sv */
/*
 * Sprite video output stage
 * Serializes sprite rows into a double line buffer and scans it out
 */
`timescale 1ns/1ps
`default_nettype none

module spriteVideo
	import spritePkg::*;
#(
	parameter int H_TOTAL = 384,
	parameter int H_VISIBLE = 256,
	parameter int H_SYNC_START = 296,
	parameter int H_SYNC_LEN = 32,
	parameter int V_TOTAL = 264,
	parameter int V_VISIBLE = 224,
	parameter int V_SYNC_START = 240,
	parameter int V_SYNC_LEN = 8
) (
	input wire logic clk_12M,
	input wire logic RES,
	input wire logic load,
	input planeByte_t plane0,
	input planeByte_t plane1,
	input planeByte_t plane2,
	input planeByte_t plane3,
	input colour_t colour,
	input xPos_t xPos,
	output logic busy,
	output pixelCode_t ob,
	output logic nOpaque,
	output logic nHBlank,
	output logic nVBlank,
	output logic nHSync,
	output logic nVSync,
	output logic nCSync
);

	xPos_t hCount;
	logic visible;
	logic newLine;
	logic nHBlankRaw, nVBlankRaw, nHSyncRaw, nVSyncRaw;	// Undelayed timing
	logic wrEn;
	xPos_t wrAddr;
	pixelCode_t wrData;
	pixelCode_t rdData;

	videoTiming #(
		.H_TOTAL(H_TOTAL),
		.H_VISIBLE(H_VISIBLE),
		.H_SYNC_START(H_SYNC_START),
		.H_SYNC_LEN(H_SYNC_LEN),
		.V_TOTAL(V_TOTAL),
		.V_VISIBLE(V_VISIBLE),
		.V_SYNC_START(V_SYNC_START),
		.V_SYNC_LEN(V_SYNC_LEN)
	) i_timing (
		.clk_12M(clk_12M), .RES(RES),
		.hCount(hCount), .visible(visible), .newLine(newLine),
		.nHBlank(nHBlankRaw), .nVBlank(nVBlankRaw),
		.nHSync(nHSyncRaw), .nVSync(nVSyncRaw)
	);

	spriteSerializer i_serializer (
		.clk_12M(clk_12M), .RES(RES), .load(load),
		.plane0(plane0), .plane1(plane1), .plane2(plane2), .plane3(plane3),
		.colour(colour), .xPos(xPos), .newLine(newLine), .busy(busy),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
	);

	lineBuffer #(
		.H_VISIBLE(H_VISIBLE)
	) i_lineBuffer (
		.clk_12M(clk_12M), .RES(RES), .newLine(newLine),
		.hCount(hCount), .visible(visible),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .rdData(rdData)
	);

	pixelOutput i_output (
		.clk_12M(clk_12M), .RES(RES), .rdData(rdData), .visible(visible),
		.nHBlank(nHBlankRaw), .nVBlank(nVBlankRaw),
		.nHSync(nHSyncRaw), .nVSync(nVSyncRaw),
		.ob(ob), .nOpaque(nOpaque),
		.nHBlankOut(nHBlank), .nVBlankOut(nVBlank),
		.nHSyncOut(nHSync), .nVSyncOut(nVSync), .nCSync(nCSync)
	);

endmodule

`default_nettype wire

/* tb/tb_spriteVideo.sv */
/*
 * Testbench for the sprite video stage
 * Replays sprite rows from a pattern file and checks pixels, busy and timing
 */
`timescale 1ns/1ps
`default_nettype none

module tb_spriteVideo;

	localparam int H_TOTAL = 384;
	localparam int H_VISIBLE = 256;
	localparam int H_SYNC_START = 296;
	localparam int H_SYNC_LEN = 32;
	localparam int V_TOTAL = 264;
	localparam int V_VISIBLE = 224;
	localparam int V_SYNC_START = 240;
	localparam int V_SYNC_LEN = 8;
	localparam int ROW_PIXELS = 8;
	localparam int CLK_PERIOD = 8;
	localparam int FRAME = H_TOTAL * V_TOTAL;
	localparam int RUN_CYCLES = (V_TOTAL + V_SYNC_START + 1) * H_TOTAL;	// Two vsync falls
	localparam int MAX_REC = 32;

	logic clk_12M;
	logic RES;
	logic load;
	logic [7:0] plane0, plane1, plane2, plane3;
	logic [7:0] colour;
	logic [8:0] xPos;
	logic busy;
	logic [11:0] ob;
	logic nOpaque, nHBlank, nVBlank, nHSync, nVSync, nCSync;

	int recLine [MAX_REC];
	int recX [MAX_REC];
	logic [7:0] recColour [MAX_REC];
	logic [7:0] recPlane [MAX_REC][4];
	logic [11:0] recWord [MAX_REC][12];
	int nRec = 0;

	bit [11:0] bankModel [2][512];	// Reference line buffer
	bit drawSel = 1'b0;
	int errTiming = 0, errPixel = 0, errBusy = 0, errPattern = 0, errOther = 0;
	bit hSyncPrev = 1'b1, hBlankPrev = 1'b1, vSyncPrev = 1'b1;
	int hFallCyc = -1;
	int hBlankRise = -1;
	int hFalls = 0;
	int vFalls = 0;

	spriteVideo i_dut (
		.clk_12M(clk_12M), .RES(RES), .load(load),
		.plane0(plane0), .plane1(plane1), .plane2(plane2), .plane3(plane3),
		.colour(colour), .xPos(xPos), .busy(busy), .ob(ob), .nOpaque(nOpaque),
		.nHBlank(nHBlank), .nVBlank(nVBlank), .nHSync(nHSync), .nVSync(nVSync),
		.nCSync(nCSync)
	);

	initial begin
		clk_12M = 1'b0;
		forever #(CLK_PERIOD / 2) clk_12M = ~clk_12M;
	end

	initial begin : watchdog
		#(4 * FRAME * CLK_PERIOD);
		$display("Timeout: the run did not finish within four frames");
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic readPatterns();
		int fd;
		int n;
		string textLine;
		fd = $fopen("tb/sprite_patterns.txt", "r");
		assert (fd != 0) else begin
			errOther++;
			$display("Cannot open the pattern file");
		end
		if (fd == 0)
			return;
		while (!$feof(fd) && nRec < MAX_REC) begin
			textLine = "";
			void'($fgets(textLine, fd));
			if (textLine.len() < 2 || textLine[0] == "#")
				continue;	// Blank or comment
			n = $sscanf(textLine,
				"%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				recLine[nRec], recX[nRec], recColour[nRec],
				recPlane[nRec][0], recPlane[nRec][1], recPlane[nRec][2], recPlane[nRec][3],
				recWord[nRec][0], recWord[nRec][1], recWord[nRec][2], recWord[nRec][3],
				recWord[nRec][4], recWord[nRec][5], recWord[nRec][6], recWord[nRec][7],
				recWord[nRec][8], recWord[nRec][9], recWord[nRec][10], recWord[nRec][11]);
			assert (n == 19) else begin
				errOther++;
				$display("Malformed record in the pattern file: %s", textLine);
			end
			if (n == 19)
				nRec++;
		end
		$fclose(fd);
	endtask

	// Drives one row and paints it into the reference buffer
	task automatic loadRow(input int idx);
		logic [3:0] pix;
		logic [11:0] modelWord;
		int x;
		int k;
		load = 1'b1;
		plane0 = recPlane[idx][0];
		plane1 = recPlane[idx][1];
		plane2 = recPlane[idx][2];
		plane3 = recPlane[idx][3];
		colour = recColour[idx];
		xPos = 9'(recX[idx]);
		for (k = 0; k < ROW_PIXELS; k++) begin
			pix = {recPlane[idx][3][7-k], recPlane[idx][2][7-k],
				recPlane[idx][1][7-k], recPlane[idx][0][7-k]};
			x = (recX[idx] + k) % 512;
			if (pix != 4'h0 && x < H_VISIBLE)
				bankModel[drawSel][x] = {recColour[idx], pix};
		end
		for (k = 0; k < 12; k++) begin
			x = recX[idx] - 2 + k;
			modelWord = (x >= 0 && x < H_VISIBLE) ? bankModel[drawSel][x] : 12'h000;
			assert (modelWord == recWord[idx][k]) else begin
				errPattern++;
				$display("FAILED ob (record %0d, x %0d): file %h model %h",
					idx, x, recWord[idx][k], modelWord);
			end
		end
	endtask

	task automatic issueIgnoredLoad();
		load = 1'b1;
		plane0 = 8'hff;
		plane1 = 8'hff;
		plane2 = 8'hff;
		plane3 = 8'hff;
		colour = 8'hee;
		xPos = 9'd100;
	endtask

	task automatic checkTiming(input int cyc);
		int d;
		int hd;
		int vd;
		logic expHSync;
		logic expVSync;
		logic expVBlank;
		d = (cyc >= 2) ? cyc - 2 : 0;	// Outputs trail the counters by two clocks
		hd = d % H_TOTAL;
		vd = (d / H_TOTAL) % V_TOTAL;
		expHSync = !(hd >= H_SYNC_START && hd < H_SYNC_START + H_SYNC_LEN);
		expVSync = !(vd >= V_SYNC_START && vd < V_SYNC_START + V_SYNC_LEN);
		expVBlank = (vd < V_VISIBLE);
		if (!nHSync && hSyncPrev) begin
			if (hFallCyc >= 0)
				assert (cyc - hFallCyc == H_TOTAL) else begin
					errTiming++;
					$display("FAILED nHSync period: got %0h expected %0h", cyc - hFallCyc, H_TOTAL);
				end
			hFallCyc = cyc;
			hFalls++;
		end
		if (nHSync && !hSyncPrev)
			assert (cyc - hFallCyc == H_SYNC_LEN) else begin
				errTiming++;
				$display("FAILED nHSync low: got %0h expected %0h", cyc - hFallCyc, H_SYNC_LEN);
			end
		if (nHBlank && !hBlankPrev)
			hBlankRise = cyc;
		if (!nHBlank && hBlankPrev && hBlankRise >= 0)
			assert (cyc - hBlankRise == H_VISIBLE) else begin
				errTiming++;
				$display("FAILED nHBlank high: got %0h expected %0h", cyc - hBlankRise, H_VISIBLE);
			end
		if (!nVSync && vSyncPrev) begin
			if (vFalls > 0)
				assert (hFalls == V_TOTAL) else begin
					errTiming++;
					$display("FAILED nVSync lines per frame: got %0h expected %0h", hFalls, V_TOTAL);
				end
			hFalls = 0;
			vFalls++;
		end
		assert (nVBlank == expVBlank) else begin
			errTiming++;
			$display("FAILED nVBlank at cycle %0d: got %h expected %h",
				cyc, nVBlank, expVBlank);
		end
		assert (nCSync == (expHSync & expVSync)) else begin
			errTiming++;
			$display("FAILED nCSync at cycle %0d: got %h expected %h",
				cyc, nCSync, expHSync & expVSync);
		end
		hSyncPrev = nHSync;
		hBlankPrev = nHBlank;
		vSyncPrev = nVSync;
	endtask

	initial begin : stimulus
		int cyc, h, lineNum, recIdx, busyExp, gap, errTotal;
		logic [11:0] expPipe [2];
		void'($urandom(32'hb378_0fc2));
		RES = 1'b0;
		load = 1'b0;
		plane0 = '0;
		plane1 = '0;
		plane2 = '0;
		plane3 = '0;
		colour = '0;
		xPos = '0;
		recIdx = 0;
		busyExp = 0;
		gap = 0;
		expPipe[0] = '0;
		expPipe[1] = '0;
		readPatterns();
		repeat (16) @(negedge clk_12M);
		RES = 1'b1;
		for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
			h = cyc % H_TOTAL;
			lineNum = cyc / H_TOTAL;
			if (h == 0 && cyc > 0)
				drawSel = ~drawSel;	// Swap after newLine
			checkTiming(cyc);
			if (!nHBlank || !nVBlank)
				assert (ob == 12'h000) else begin
					errPixel++;
					$display("FAILED ob in blanking: got %h expected 000", ob);
				end
			assert (ob == expPipe[1]) else begin
				errPixel++;
				$display("FAILED ob at line %0d hCount %0d: got %h expected %h",
					lineNum, h, ob, expPipe[1]);
			end
			assert (nOpaque == (expPipe[1][3:0] == 4'h0)) else begin
				errPixel++;
				$display("FAILED nOpaque: got %h expected %h", nOpaque, expPipe[1][3:0] == 4'h0);
			end
			expPipe[1] = expPipe[0];
			if (h < H_VISIBLE && (lineNum % V_TOTAL) < V_VISIBLE) begin
				expPipe[0] = bankModel[!drawSel][h];
				bankModel[!drawSel][h] = '0;	// Erase on read
			end else begin
				expPipe[0] = '0;
			end
			assert (busy == (busyExp > 0)) else begin
				errBusy++;
				$display("FAILED busy at cycle %0d: got %h expected %h", cyc, busy, busyExp > 0);
			end
			if (busyExp > 0)
				busyExp--;
			load = 1'b0;
			if (busyExp == 5) begin
				issueIgnoredLoad();	// Mid row, must be dropped
			end else if (busyExp == 0 && recIdx < nRec && recLine[recIdx] == lineNum && h >= 16) begin
				if (gap > 0) begin
					gap--;
				end else begin
					loadRow(recIdx);
					recIdx++;
					busyExp = ROW_PIXELS;
					gap = $urandom_range(6, 1);
				end
			end
			@(negedge clk_12M);
		end
		assert (nRec > 0 && recIdx == nRec) else begin
			errOther++;
			$display("Not every sprite row from the pattern file was loaded");
		end
		assert (vFalls >= 2) else begin
			errOther++;
			$display("Fewer than two vertical sync pulses were seen");
		end
		errTotal = errTiming + errPixel + errBusy + errPattern + errOther;
		$display("Errors: timing %0d, pixel %0d, busy %0d, pattern %0d, other %0d",
			errTiming, errPixel, errBusy, errPattern, errOther);
		if (errTotal == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/sprite_patterns.txt */
# line xPos colour plane0 plane1 plane2 plane3, then expected ob words for x = xPos-2 .. xPos+9
# line and xPos are decimal, everything else hex; rows show up on the following line

# Single row, then an overlapping row with transparent pixels
2 40 5a a5 3c f0 81 000 000 5ad 5a4 5a7 5a6 5a2 5a3 000 5a9 000 000
2 43 33 c3 00 00 0c 5a4 5a7 331 331 5a3 000 338 338 331 331 000 000

# Clipped at the right edge, and a row at the left edge
5 252 7e ff ff 00 00 000 000 7e3 7e3 7e3 7e3 000 000 000 000 000 000
5 0 01 01 02 04 08 000 000 000 000 000 000 018 014 012 011 000 000

# Solid row, an all-transparent row and a sparse row on top
9 128 ff ff ff ff ff 000 000 fff fff fff fff fff fff fff fff 000 000
9 130 10 00 00 00 00 fff fff fff fff fff fff fff fff 000 000 000 000
9 132 42 00 00 aa 00 fff fff 424 fff 424 fff 424 000 424 000 000 000

# One pixel per plane
12 200 c7 80 40 20 10 000 000 c71 c72 c74 c78 000 000 000 000 000 000

/* compile.f */
source/spritePkg.sv
source/videoTiming.sv
source/spriteSerializer.sv
source/lineBuffer.sv
source/pixelOutput.sv
source/spriteVideo.sv
tb/tb_spriteVideo.sv

/* Makefile */
# Verilator build and run for the sprite video stage

TOP = tb_spriteVideo
LOG = sim.log
RTL = source/spritePkg.sv source/videoTiming.sv source/spriteSerializer.sv \
	source/lineBuffer.sv source/pixelOutput.sv source/spriteVideo.sv

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(RTL) tb/tb_spriteVideo.sv
	verilator --binary --timing --top-module $(TOP) -f compile.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --top-module spriteVideo $(RTL)

clean:
	rm -rf obj_dir $(LOG)
